/* bench/memoryChecker.sv */
module memoryChecker import memAccessPkg::*;
(
    input  logic        Clock,
    input  logic        rstN,
    input  logic        reqValid,
    input  logic        reqWrite,
    input  logic [1:0]  reqSize,
    input  logic        reqUnsigned,
    input  logic [31:0] reqAddress,
    input  logic [31:0] storeData,
    input  logic        loadValid,
    input  logic [31:0] loadData,
    input  logic        requestError,
    output int          errorCount,
    output int          pendingCount
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] modelWords [memDepth];
    logic [31:0] expectedQ [$];
    int          dueQ [$];
    int          edgeCount;
    logic        errorDue;

    initial
    begin
        errorCount   = 0;
        pendingCount = 0;
        edgeCount    = 0;
        errorDue     = 1'b0;
        for (int i = 0; i < memDepth; i++)
        begin
            modelWords[i] = '0;
        end
        $readmemh(memInitFile, modelWords);
    end

    //////////////////////////////////////////////////
    // Reference rules
    //////////////////////////////////////////////////
    function automatic bit isRejected(logic [1:0] size, logic [1:0] offset);
        return size == 2'd3 || (size == sizeWord && offset != 2'd0) ||
               (size == sizeHalf && offset[0]);
    endfunction

    // Move the addressed lane to the top, then extend it down
    function automatic logic [31:0] expectedLoad(logic [31:0] word, logic [1:0] offset,
                                                 logic [1:0] size, logic isUnsigned);
        logic [31:0] shifted;
        logic        fill;
        shifted = word << (8 * offset);
        fill    = !isUnsigned && shifted[31];
        case (size)
            sizeHalf: return {{16{fill}}, shifted[31:16]};
            sizeByte: return {{24{fill}}, shifted[31:24]};
            default:  return word;
        endcase
    endfunction

    task automatic storeIntoModel(int index, logic [1:0] offset, logic [1:0] size,
                                  logic [31:0] data);
        case (size)
            sizeWord: modelWords[index] = data;
            sizeHalf: modelWords[index][31 - 8*offset -: 16] = data[15:0];
            default:  modelWords[index][31 - 8*offset -: 8] = data[7:0];
        endcase
    endtask

    //////////////////////////////////////////////////
    // Compare on every edge after reset
    //////////////////////////////////////////////////
    always @(posedge Clock)
    begin
        logic [31:0] expected;
        int          due;
        int          index;
        if (rstN)
        begin
            edgeCount++;
            if (requestError !== errorDue)
            begin
                $display("Fail requestError expected %h actual %h", errorDue, requestError);
                errorCount++;
            end
            if (loadValid === 1'b1)
            begin
                if (expectedQ.size() == 0)
                begin
                    $display("Load result arrived with no load outstanding");
                    errorCount++;
                end
                else
                begin
                    expected = expectedQ.pop_front();
                    due      = dueQ.pop_front();
                    if (due != edgeCount)
                    begin
                        $display("Load result came at edge %0d instead of edge %0d",
                                 edgeCount, due);
                        errorCount++;
                    end
                    if (loadData !== expected)
                    begin
                        $display("Fail loadData expected %h actual %h", expected, loadData);
                        errorCount++;
                    end
                end
            end
            else if (dueQ.size() > 0 && dueQ[0] <= edgeCount)
            begin
                $display("Load result missing at edge %0d", edgeCount);
                void'(expectedQ.pop_front());
                void'(dueQ.pop_front());
                errorCount++;
            end
            // Request sampled at this edge
            errorDue = reqValid && isRejected(reqSize, reqAddress[1:0]);
            if (reqValid && !errorDue)
            begin
                index = reqAddress[11:2];
                if (reqWrite)
                    storeIntoModel(index, reqAddress[1:0], reqSize, storeData);
                else
                begin
                    expectedQ.push_back(expectedLoad(modelWords[index], reqAddress[1:0],
                                                     reqSize, reqUnsigned));
                    dueQ.push_back(edgeCount + 3);
                end
            end
            pendingCount = expectedQ.size();
        end
    end

endmodule

/* bench/memoryStageTb.sv */
module memoryStageTb import memAccessPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic        Clock;
    logic        rstN;
    logic        reqValid;
    logic        reqWrite;
    memSizeT     reqSize;
    logic        reqUnsigned;
    logic [31:0] reqAddress;
    logic [31:0] storeData;
    logic        loadValid;
    logic [31:0] loadData;
    logic        requestError;
    int          errorCount;
    int          pendingCount;

    always #4 Clock = ~Clock;

    memoryStage memoryStage_inst (.*);

    memoryChecker loadCheck (.*);

    task automatic issueRequest(input logic write, input memSizeT size, input logic isUnsigned,
                                input logic [31:0] address, input logic [31:0] data);
        @(posedge Clock);
        reqValid    <= 1'b1;
        reqWrite    <= write;
        reqSize     <= size;
        reqUnsigned <= isUnsigned;
        reqAddress  <= address;
        storeData   <= data;
    endtask

    task automatic idleCycles(input int count);
        repeat (count)
        begin
            @(posedge Clock);
            reqValid <= 1'b0;
        end
    endtask

    initial
    begin
        int   sizeCode;
        int   offset;
        int   quietEdges;
        bit   drainTimedOut;
        Clock       = 1'b0;
        rstN        = 1'b0;
        reqValid    = 1'b0;
        reqWrite    = 1'b0;
        reqSize     = sizeWord;
        reqUnsigned = 1'b0;
        reqAddress  = '0;
        storeData   = '0;
        void'($urandom(32'h854fc963));
        repeat (3) @(posedge Clock);
        rstN <= 1'b1;
        idleCycles(2);

        //////////////////////////////////////////////////
        // Directed phase
        //////////////////////////////////////////////////
        // Init file contents
        for (int w = 0; w < 10; w++)
        begin
            issueRequest(1'b0, sizeWord, 1'b0, w * 4, '0);
        end
        // Signed then unsigned byte loads right behind the store
        issueRequest(1'b1, sizeWord, 1'b0, 32'h40, 32'h80c17f23);
        for (int b = 0; b < 8; b++)
        begin
            issueRequest(1'b0, sizeByte, b >= 4, 32'h40 + b % 4, '0);
        end
        // Halfword stores touch only their own half
        issueRequest(1'b1, sizeWord, 1'b0, 32'h50, 32'h11223344);
        issueRequest(1'b1, sizeHalf, 1'b0, 32'h52, 32'haaaabeef);
        issueRequest(1'b0, sizeWord, 1'b0, 32'h50, '0);
        issueRequest(1'b1, sizeHalf, 1'b0, 32'h50, 32'h00008001);
        issueRequest(1'b0, sizeWord, 1'b0, 32'h50, '0);
        issueRequest(1'b0, sizeHalf, 1'b0, 32'h50, '0);
        issueRequest(1'b0, sizeHalf, 1'b1, 32'h52, '0);
        // Rejected requests leave word 16 alone
        issueRequest(1'b1, sizeWord, 1'b0, 32'h41, 32'hffffffff);
        issueRequest(1'b1, sizeHalf, 1'b0, 32'h43, 32'hffffffff);
        issueRequest(1'b1, memSizeT'(2'd3), 1'b0, 32'h40, 32'hffffffff);
        issueRequest(1'b0, sizeWord, 1'b0, 32'h42, '0);
        idleCycles(1);
        issueRequest(1'b0, sizeWord, 1'b0, 32'h40, '0);
        idleCycles(3);

        //////////////////////////////////////////////////
        // Random phase over the first 64 words
        //////////////////////////////////////////////////
        for (int n = 0; n < 400; n++)
        begin
            sizeCode = $urandom_range(0, 2);
            offset   = $urandom_range(0, 3);
            if ($urandom_range(0, 15) == 0)
                sizeCode = 3;
            else if ($urandom_range(0, 7) != 0)
                offset = (sizeCode == 0) ? 0 : (sizeCode == 1) ? offset & 2 : offset;
            issueRequest($urandom_range(0, 1), memSizeT'(sizeCode), $urandom_range(0, 1),
                         $urandom_range(0, 63) * 4 + offset, $urandom());
            if ($urandom_range(0, 4) == 0)
                idleCycles(1);
        end
        idleCycles(1);

        // Drain the pipeline
        drainTimedOut = 1'b1;
        quietEdges    = 0;
        for (int tick = 0; tick < 50 && drainTimedOut; tick++)
        begin
            @(negedge Clock);
            quietEdges = (pendingCount == 0) ? quietEdges + 1 : 0;
            if (quietEdges >= 3)
                drainTimedOut = 1'b0;
        end
        if (drainTimedOut)
            $display("Timed out waiting for outstanding loads to complete");
        if (pendingCount != 0)
            $display("%0d loads never returned a result", pendingCount);
        $display("Error count %0d, outstanding loads %0d", errorCount, pendingCount);
        if (errorCount == 0 && pendingCount == 0 && !drainTimedOut)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* dataMemoryInit.mem */
// Initial memory contents, one 32-bit hex word per line
// Line n holds word n, starting at byte address 0
01234567
89abcdef
deadbeef
00000080
7f80ff01
cafef00d
12345678
fedcba98
80000000
0000ffff

/* memoryStage.f */
verilog/memAccessPkg.sv
verilog/memStageIfs.sv
verilog/loadStoreIssue.sv
verilog/dataMemory.sv
verilog/loadAlign.sv
verilog/memoryStage.sv
bench/memoryChecker.sv
bench/memoryStageTb.sv

/* verilog/dataMemory.sv */
module dataMemory import memAccessPkg::*;
(
    input  logic     Clock,
    input  logic     rstN,
    memReqIf.memory  req,
    memRespIf.memory resp
);

    logic [dataWidth-1:0] memWords [memDepth];

    //////////////////////////////////////////////////
    // Initial contents
    //////////////////////////////////////////////////
    initial
    begin
        // Words past the end of the file stay zero
        for (int i = 0; i < memDepth; i++)
        begin
            memWords[i] = '0;
        end
        $readmemh(memInitFile, memWords);
    end

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////
    always @(posedge Clock)
    begin
        if (req.valid && req.write)
        begin
            for (int lane = 0; lane < laneCount; lane++)
            begin
                // Enable bit 3 maps to the top byte
                if (req.byteEnable[laneCount-1-lane])
                begin
                    memWords[req.wordIndex][dataWidth-1-lane*laneWidth -: laneWidth] <=
                        req.writeData[dataWidth-1-lane*laneWidth -: laneWidth];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////
    always_ff @(posedge Clock)
    begin
        if (req.valid && !req.write)
        begin
            resp.readWord   <= memWords[req.wordIndex];
            resp.laneOffset <= req.laneOffset;
            resp.size       <= req.size;
            resp.isUnsigned <= req.isUnsigned;
        end
    end

    // Response strobe for loads only
    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
            resp.valid <= 1'b0;
        else
            resp.valid <= req.valid && !req.write;
    end

    storeHasLanes: assert property (@(posedge Clock) disable iff (!rstN)
        req.valid && req.write |-> req.byteEnable != '0);

endmodule

/* verilog/loadAlign.sv */
module loadAlign import memAccessPkg::*;
(
    input  logic          Clock,
    input  logic          rstN,
    memRespIf.align       resp,
    output logic          loadValid,
    output logic [31:0]   loadData
);

    logic [laneWidth-1:0] pickedByte;
    logic [halfWidth-1:0] pickedHalf;
    logic                 fillBit;
    logic [dataWidth-1:0] extended;

    //////////////////////////////////////////////////
    // Lane select and extension
    //////////////////////////////////////////////////
    always_comb
    begin
        pickedByte = resp.readWord[(laneCount-1-resp.laneOffset)*laneWidth +: laneWidth];
        pickedHalf = resp.laneOffset[1] ? resp.readWord[halfWidth-1:0]
                                        : resp.readWord[dataWidth-1:halfWidth];
        fillBit    = 1'b0;
        case (resp.size)
            sizeByte:
            begin
                fillBit  = !resp.isUnsigned && pickedByte[laneWidth-1];
                extended = {{(dataWidth-laneWidth){fillBit}}, pickedByte};
            end
            sizeHalf:
            begin
                fillBit  = !resp.isUnsigned && pickedHalf[halfWidth-1];
                extended = {{(dataWidth-halfWidth){fillBit}}, pickedHalf};
            end
            default:
                extended = resp.readWord;  // word load as is
        endcase
    end

    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
            loadValid <= 1'b0;
        else
            loadValid <= resp.valid;
    end

    always_ff @(posedge Clock)
    begin
        if (resp.valid)
            loadData <= extended;
    end

    // Issue stage filters odd halfword offsets
    halfAligned: assert property (@(posedge Clock) disable iff (!rstN)
        resp.valid && resp.size == sizeHalf |-> !resp.laneOffset[0]);

endmodule

/* verilog/loadStoreIssue.sv */
module loadStoreIssue import memAccessPkg::*;
(
    input  logic        Clock,
    input  logic        rstN,
    input  logic        reqValid,
    input  logic        reqWrite,
    input  memSizeT     reqSize,
    input  logic        reqUnsigned,
    input  logic [31:0] reqAddress,
    input  logic [31:0] storeData,
    output logic        requestError,
    memReqIf.issue      req
);

    laneOffsetT           offset;
    logic                 badRequest;
    byteEnableT           laneEnable;
    logic [dataWidth-1:0] laneData;

    assign offset = reqAddress[1:0];

    //////////////////////////////////////////////////
    // Alignment check and lane placement
    //////////////////////////////////////////////////
    always_comb
    begin
        badRequest = 1'b0;
        laneEnable = '0;
        laneData   = storeData;
        case (reqSize)
            sizeWord:
            begin
                badRequest = (offset != 2'd0);
                laneEnable = '1;
            end
            sizeHalf:
            begin
                badRequest = offset[0];
                // Offset 0 is the upper half
                laneEnable = offset[1] ? 4'b0011 : 4'b1100;
                laneData   = {2{storeData[halfWidth-1:0]}};
            end
            sizeByte:
            begin
                laneEnable = 4'b1000 >> offset;
                laneData   = {laneCount{storeData[laneWidth-1:0]}};
            end
            default:
                badRequest = 1'b1;  // reserved size code
        endcase
    end

    // Strobes
    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
        begin
            req.valid    <= 1'b0;
            requestError <= 1'b0;
        end
        else
        begin
            req.valid    <= reqValid && !badRequest;
            requestError <= reqValid && badRequest;
        end
    end

    // Request fields held until the next good request
    always_ff @(posedge Clock)
    begin
        if (reqValid && !badRequest)
        begin
            req.write      <= reqWrite;
            req.wordIndex  <= reqAddress[wordIndexWidth+1:2];
            req.byteEnable <= laneEnable;
            req.writeData  <= laneData;
            req.laneOffset <= offset;
            req.size       <= reqSize;
            req.isUnsigned <= reqUnsigned;
        end
    end

    reqValidKnown: assert property (@(posedge Clock) disable iff (!rstN)
        !$isunknown(reqValid));

endmodule

/* verilog/memAccessPkg.sv */
package memAccessPkg;

    //////////////////////////////////////////////////
    // Access size codes with code 3 reserved
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        sizeWord = 2'd0,
        sizeHalf = 2'd1,
        sizeByte = 2'd2
    } memSizeT;

    // Storage geometry
    localparam int memDepth       = 1024;
    localparam int wordIndexWidth = 10;
    localparam int dataWidth      = 32;

    // Lane mapping with lane 0 as the most significant byte
    localparam int laneCount = 4;
    localparam int laneWidth = 8;
    localparam int halfWidth = 16;

    // Shared by the memory and the bench model
    localparam string memInitFile = "dataMemoryInit.mem";

    // Word address into the storage
    typedef logic [wordIndexWidth-1:0] wordIndexT;

    // One bit per lane with bit 3 on data bits 31:24
    typedef logic [laneCount-1:0] byteEnableT;

    // Byte offset within the word
    typedef logic [1:0] laneOffsetT;

endpackage

/* verilog/memStageIfs.sv */
//////////////////////////////////////////////////
// Request path from issue stage to memory array
//////////////////////////////////////////////////
interface memReqIf import memAccessPkg::*; ();

    logic                 valid;
    logic                 write;
    wordIndexT            wordIndex;
    byteEnableT           byteEnable;
    logic [dataWidth-1:0] writeData;
    laneOffsetT           laneOffset;
    memSizeT              size;
    logic                 isUnsigned;

    modport issue (output valid, write, wordIndex, byteEnable, writeData,
                   laneOffset, size, isUnsigned);

    modport memory (input valid, write, wordIndex, byteEnable, writeData,
                    laneOffset, size, isUnsigned);

endinterface

//////////////////////////////////////////////////
// Load response path from memory array to aligner
//////////////////////////////////////////////////
interface memRespIf import memAccessPkg::*; ();

    // Strobed for loads only
    logic                 valid;
    logic [dataWidth-1:0] readWord;
    laneOffsetT           laneOffset;
    memSizeT              size;
    logic                 isUnsigned;

    modport memory (output valid, readWord, laneOffset, size, isUnsigned);

    modport align (input valid, readWord, laneOffset, size, isUnsigned);

endinterface

/* verilog/memoryStage.sv */
module memoryStage import memAccessPkg::*;
(
    input  logic        Clock,
    input  logic        rstN,
    input  logic        reqValid,
    input  logic        reqWrite,
    input  memSizeT     reqSize,
    input  logic        reqUnsigned,
    input  logic [31:0] reqAddress,
    input  logic [31:0] storeData,
    output logic        loadValid,
    output logic [31:0] loadData,
    output logic        requestError
);

    memReqIf  reqBus ();
    memRespIf respBus ();

    loadStoreIssue issueStage (
        .Clock        (Clock),
        .rstN         (rstN),
        .reqValid     (reqValid),
        .reqWrite     (reqWrite),
        .reqSize      (reqSize),
        .reqUnsigned  (reqUnsigned),
        .reqAddress   (reqAddress),
        .storeData    (storeData),
        .requestError (requestError),
        .req          (reqBus.issue)
    );

    dataMemory memoryArray (
        .Clock (Clock),
        .rstN  (rstN),
        .req   (reqBus.memory),
        .resp  (respBus.memory)
    );

    // Load result appears three edges after sampling
    loadAlign alignStage (
        .Clock     (Clock),
        .rstN      (rstN),
        .resp      (respBus.align),
        .loadValid (loadValid),
        .loadData  (loadData)
    );

endmodule
